//--- exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data word width
`define EXEC_XLEN 32

// Destination register index width
`define EXEC_REG_W 5

// Iterations of the shift-add multiplier, one product bit each
`define EXEC_MUL_CYCLES 32

// Width of the ALU operation code
`define EXEC_ALUOP_W 4

`endif

//--- exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0]  word_t;
  typedef logic [`EXEC_REG_W-1:0] reg_idx_t;

  typedef enum logic [`EXEC_ALUOP_W-1:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
  } aluop_t;

  typedef enum logic [2:0] {
    BEQ, BNE, BLT, BGE, BLTU, BGEU
  } br_type_t;

  // Arithmetic request, w_src high passes reg_file_wdata through
  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    aluop_t   aluop;
    logic     w_src;
    word_t    port_a;
    word_t    port_b;
    word_t    reg_file_wdata;
  } arith_req_t;

  // is_signed[0] qualifies rs1_data, is_signed[1] qualifies rs2_data
  typedef struct packed {
    logic       start;
    reg_idx_t   rd;
    logic [1:0] is_signed;
    logic       high_low_sel;
    word_t      rs1_data;
    word_t      rs2_data;
  } mul_req_t;

  typedef struct packed {
    logic     branch_instr;
    logic     prediction;
    br_type_t br_type;
    word_t    pc;
    word_t    imm_sb;
    word_t    rs1_data;
    word_t    rs2_data;
  } branch_req_t;

  // j_sel high selects pc as the jump base
  typedef struct packed {
    logic  jump_instr;
    logic  j_sel;
    word_t pc;
    word_t rs1_data;
    word_t offset;
  } jump_req_t;

  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;
  } wb_slot_t;

  typedef struct packed {
    wb_slot_t au;
    wb_slot_t mu;
  } commit_wb_t;

  typedef struct packed {
    logic  branch_instr;
    logic  branch_taken;
    logic  prediction;
    word_t br_resolved_addr;
    word_t pc4;
    logic  jump_instr;
    word_t jump_addr;
    logic  halt_instr;
    logic  intr_seen;
  } commit_ctl_t;

endpackage

`default_nettype wire

//--- alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module alu_unit (
  input  exec_pkg::arith_req_t req,
  output exec_pkg::wb_slot_t   slot
);

  import exec_pkg::*;

  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  logic [SHAMT_W-1:0] shamt;
  word_t              result;

  // Only the low bits of port_b count as shift amount
  assign shamt = req.port_b[SHAMT_W-1:0];

  always_comb begin
    case (req.aluop)
      ADD:     result = req.port_a + req.port_b;
      SUB:     result = req.port_a - req.port_b;
      AND:     result = req.port_a & req.port_b;
      OR:      result = req.port_a | req.port_b;
      XOR:     result = req.port_a ^ req.port_b;
      SLL:     result = req.port_a << shamt;
      SRL:     result = req.port_a >> shamt;
      SRA:     result = word_t'($signed(req.port_a) >>> shamt);
      SLT:     result = word_t'($signed(req.port_a) < $signed(req.port_b));
      SLTU:    result = word_t'(req.port_a < req.port_b);
      default: result = '0;
    endcase
  end

  // Write source picks between the ALU and the precomputed value
  always_comb begin
    slot.wen   = req.wen;
    slot.rd    = req.rd;
    slot.wdata = req.w_src ? req.reg_file_wdata : result;
  end

endmodule

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module mul_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  exec_pkg::mul_req_t req,
  output logic               busy,
  output exec_pkg::wb_slot_t slot
);

  import exec_pkg::*;

  localparam int XLEN  = `EXEC_XLEN;
  localparam int CNT_W = $clog2(`EXEC_MUL_CYCLES);

  logic              a_neg;
  logic              b_neg;
  word_t             a_mag;
  word_t             b_mag;
  word_t             mcand;
  logic [2*XLEN-1:0] acc;
  logic [2*XLEN-1:0] product;
  logic [XLEN:0]     partial;
  logic [XLEN:0]     sum;
  logic [CNT_W-1:0]  count;
  logic              neg_q;
  logic              hi_q;
  reg_idx_t          rd_q;
  logic              done;

  // Operand magnitudes for the unsigned core
  assign a_neg = req.is_signed[0] & req.rs1_data[XLEN-1];
  assign b_neg = req.is_signed[1] & req.rs2_data[XLEN-1];
  assign a_mag = a_neg ? -req.rs1_data : req.rs1_data;
  assign b_mag = b_neg ? -req.rs2_data : req.rs2_data;

  // Multiplier bits sit in the low half and drain out one per cycle
  assign partial = acc[0] ? {1'b0, mcand} : '0;
  assign sum     = {1'b0, acc[2*XLEN-1:XLEN]} + partial;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
      acc   <= '0;
      mcand <= '0;
      neg_q <= 1'b0;
      hi_q  <= 1'b0;
      rd_q  <= '0;
    end else begin
      done <= 1'b0;
      if (busy) begin
        acc   <= {sum, acc[XLEN-1:1]};
        count <= count + 1'b1;
        // Last iteration, result valid next cycle
        if (count == CNT_W'(`EXEC_MUL_CYCLES - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end else if (req.start) begin
        busy  <= 1'b1;
        count <= '0;
        mcand <= a_mag;
        acc   <= {{XLEN{1'b0}}, b_mag};
        neg_q <= a_neg ^ b_neg;
        hi_q  <= req.high_low_sel;
        rd_q  <= req.rd;
      end
    end
  end

  // Restore the sign of the full product
  assign product = neg_q ? -acc : acc;

  always_comb begin
    slot.wen   = done;
    slot.rd    = rd_q;
    slot.wdata = hi_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
  end

endmodule

`default_nettype wire

//--- branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  exec_pkg::branch_req_t br,
  input  exec_pkg::jump_req_t   jmp,
  output logic                  taken,
  output exec_pkg::word_t       resolved_addr,
  output exec_pkg::word_t       jump_addr,
  output exec_pkg::word_t       brj_addr,
  output logic                  mispredict
);

  import exec_pkg::*;

  logic  eq;
  logic  lt;
  logic  ltu;
  word_t br_target;
  word_t jump_base;
  word_t jump_sum;

  assign eq  = (br.rs1_data == br.rs2_data);
  assign lt  = ($signed(br.rs1_data) < $signed(br.rs2_data));
  assign ltu = (br.rs1_data < br.rs2_data);

  always_comb begin
    case (br.br_type)
      BEQ:     taken = eq;
      BNE:     taken = ~eq;
      BLT:     taken = lt;
      BGE:     taken = ~lt;
      BLTU:    taken = ltu;
      BGEU:    taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  // Fall through to the next sequential instruction when not taken
  assign br_target     = br.pc + br.imm_sb;
  assign resolved_addr = taken ? br_target : br.pc + word_t'(4);

  // JALR style targets clear bit 0
  assign jump_base = jmp.j_sel ? jmp.pc : jmp.rs1_data;
  assign jump_sum  = jump_base + jmp.offset;
  assign jump_addr = {jump_sum[$bits(word_t)-1:1], 1'b0};

  assign brj_addr   = jmp.jump_instr ? jump_addr : resolved_addr;
  assign mispredict = br.branch_instr & (br.prediction ^ taken);

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     halt,
  input  logic     pc_en,
  input  logic     ex_flush,
  input  payload_t d,
  output payload_t q
);

  // Flush only takes effect on an enabled cycle, halt always wins
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (halt || (ex_flush && pc_en)) begin
      q <= '0;
    end else if (pc_en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- ooo_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_execute_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  halt,
  input  logic                  pc_en,
  input  logic                  ex_flush,
  input  logic                  intr,
  input  logic                  intr_taken,
  input  logic                  halt_instr,
  input  exec_pkg::arith_req_t  arith,
  input  exec_pkg::mul_req_t    mul,
  input  exec_pkg::branch_req_t br,
  input  exec_pkg::jump_req_t   jmp,
  output logic                  mul_busy,
  output logic                  mispredict,
  output exec_pkg::word_t       brj_addr,
  output exec_pkg::commit_wb_t  comm_wb,
  output exec_pkg::commit_ctl_t comm_ctl
);

  import exec_pkg::*;

  wb_slot_t    au_slot;
  wb_slot_t    mu_slot;
  logic        br_taken;
  word_t       resolved_addr;
  word_t       jump_addr;
  logic        intr_latch;
  commit_wb_t  wb_d;
  commit_ctl_t ctl_d;

  alu_unit u_alu (
    .req  (arith),
    .slot (au_slot)
  );

  mul_unit u_mul (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (mul),
    .busy (mul_busy),
    .slot (mu_slot)
  );

  branch_resolve u_brj (
    .br            (br),
    .jmp           (jmp),
    .taken         (br_taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr),
    .brj_addr      (brj_addr),
    .mispredict    (mispredict)
  );

  // Interrupt seen latch keeps sampling even while the pipe is stalled
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      intr_latch <= 1'b0;
    end else if (halt) begin
      intr_latch <= 1'b0;
    end else if (intr) begin
      intr_latch <= 1'b1;
    end else if (intr_taken) begin
      intr_latch <= 1'b0;
    end
  end

  always_comb begin
    wb_d.au = au_slot;
    wb_d.mu = mu_slot;
  end

  always_comb begin
    ctl_d.branch_instr     = br.branch_instr;
    ctl_d.branch_taken     = br_taken;
    ctl_d.prediction       = br.prediction;
    ctl_d.br_resolved_addr = resolved_addr;
    ctl_d.pc4              = br.pc + word_t'(4);
    ctl_d.jump_instr       = jmp.jump_instr;
    ctl_d.jump_addr        = jump_addr;
    ctl_d.halt_instr       = halt_instr;
    ctl_d.intr_seen        = intr_latch;
  end

  // Writeback and control records to commit
  stage_reg #(.payload_t(commit_wb_t)) wb_reg (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .pc_en    (pc_en),
    .ex_flush (ex_flush),
    .d        (wb_d),
    .q        (comm_wb)
  );

  stage_reg #(.payload_t(commit_ctl_t)) ctl_reg (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .pc_en    (pc_en),
    .ex_flush (ex_flush),
    .d        (ctl_d),
    .q        (comm_ctl)
  );

endmodule

`default_nettype wire

//--- ooo_execute_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module ooo_execute_stage_chk (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  halt,
  input logic                  pc_en,
  input logic                  ex_flush,
  input logic                  intr,
  input logic                  intr_taken,
  input logic                  halt_instr,
  input exec_pkg::arith_req_t  arith,
  input exec_pkg::mul_req_t    mul,
  input exec_pkg::branch_req_t br,
  input exec_pkg::jump_req_t   jmp,
  input logic                  mul_busy,
  input logic                  mispredict,
  input exec_pkg::word_t       brj_addr,
  input exec_pkg::commit_wb_t  comm_wb,
  input exec_pkg::commit_ctl_t comm_ctl
);

  import exec_pkg::*;

  bit       failed = 1'b0;
  wb_slot_t exp_mu;
  logic     intr_model;

  function automatic wb_slot_t alu_value(input arith_req_t r);
    logic [63:0] ext;
    int          sh;
    word_t       v;
    wb_slot_t    s;
    sh  = r.port_b[4:0];
    ext = {{32{r.port_a[31]}}, r.port_a} >> sh;
    case (r.aluop)
      ADD:     v = r.port_a + r.port_b;
      SUB:     v = r.port_a + ~r.port_b + 32'd1;
      AND:     v = r.port_a & r.port_b;
      OR:      v = r.port_a | r.port_b;
      XOR:     v = r.port_a ^ r.port_b;
      SLL:     v = r.port_a << sh;
      SRL:     v = r.port_a >> sh;
      SRA:     v = ext[31:0];
      SLT:     v = {31'd0, (r.port_a ^ 32'h8000_0000) < (r.port_b ^ 32'h8000_0000)};
      SLTU:    v = {31'd0, r.port_a < r.port_b};
      default: v = '0;
    endcase
    s.wen   = r.wen;
    s.rd    = r.rd;
    s.wdata = r.w_src ? r.reg_file_wdata : v;
    return s;
  endfunction

  // Sign or zero extend each operand, then keep the selected half
  function automatic word_t mul_value(input mul_req_t m);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] p;
    a = {{32{m.is_signed[0] & m.rs1_data[31]}}, m.rs1_data};
    b = {{32{m.is_signed[1] & m.rs2_data[31]}}, m.rs2_data};
    p = a * b;
    return m.high_low_sel ? p[63:32] : p[31:0];
  endfunction

  function automatic logic br_taken(input branch_req_t b);
    logic slt;
    slt = (b.rs1_data ^ 32'h8000_0000) < (b.rs2_data ^ 32'h8000_0000);
    case (b.br_type)
      BEQ:     return b.rs1_data == b.rs2_data;
      BNE:     return b.rs1_data != b.rs2_data;
      BLT:     return slt;
      BGE:     return !slt;
      BLTU:    return b.rs1_data < b.rs2_data;
      BGEU:    return b.rs1_data >= b.rs2_data;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t br_addr(input branch_req_t b);
    return br_taken(b) ? b.pc + b.imm_sb : b.pc + 32'd4;
  endfunction

  function automatic word_t jmp_addr(input jump_req_t j);
    return ((j.j_sel ? j.pc : j.rs1_data) + j.offset) & ~32'd1;
  endfunction

  // Whole control record expected one edge after its inputs
  function automatic commit_ctl_t ctl_value(input branch_req_t b, input jump_req_t j,
                                            input logic hi, input logic seen);
    commit_ctl_t c;
    c.branch_instr     = b.branch_instr;
    c.branch_taken     = br_taken(b);
    c.prediction       = b.prediction;
    c.br_resolved_addr = br_addr(b);
    c.pc4              = b.pc + 32'd4;
    c.jump_instr       = j.jump_instr;
    c.jump_addr        = jmp_addr(j);
    c.halt_instr       = hi;
    c.intr_seen        = seen;
    return c;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exp_mu     <= '0;
      intr_model <= 1'b0;
    end else begin
      // Slot the multiplier should present in its done cycle
      if (mul.start && !mul_busy) begin
        exp_mu.wen   <= 1'b1;
        exp_mu.rd    <= mul.rd;
        exp_mu.wdata <= mul_value(mul);
      end
      if (halt) begin
        intr_model <= 1'b0;
      end else if (intr) begin
        intr_model <= 1'b1;
      end else if (intr_taken) begin
        intr_model <= 1'b0;
      end
    end
  end

  a_alu: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST) && $past(pc_en) && !$past(halt) && !$past(ex_flush) |->
      comm_wb.au == alu_value($past(arith)))
    else begin
      $error("Fail at %0t: comm_wb.au got %h expected %h", $realtime,
             $sampled(comm_wb.au), alu_value($past(arith)));
      failed = 1'b1;
    end

  a_mul_busy: assert property (@(posedge CLK) disable iff (!nRST)
    mul.start && !mul_busy |=> mul_busy [*`EXEC_MUL_CYCLES] ##1 !mul_busy)
    else begin
      $error("Multiply busy window did not last the expected number of cycles");
      failed = 1'b1;
    end

  a_mul_res: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST, 2) && !$past(mul_busy) && $past(mul_busy, 2) && $past(pc_en)
    && !$past(halt) && !$past(ex_flush) |->
      comm_wb.mu == $past(exp_mu))
    else begin
      $error("Fail at %0t: comm_wb.mu got %h expected %h", $realtime,
             $sampled(comm_wb.mu), $past(exp_mu));
      failed = 1'b1;
    end

  a_mul_idle: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST, 2) && !(!$past(mul_busy) && $past(mul_busy, 2)) && $past(pc_en)
    && !$past(halt) && !$past(ex_flush) |->
      !comm_wb.mu.wen)
    else begin
      $error("Fail at %0t: comm_wb.mu.wen got %b expected 0", $realtime,
             $sampled(comm_wb.mu.wen));
      failed = 1'b1;
    end

  a_branch: assert property (@(posedge CLK) disable iff (!nRST)
    br.branch_instr && !jmp.jump_instr |-> brj_addr == br_addr(br))
    else begin
      $error("Fail at %0t: brj_addr got %h expected %h", $realtime, brj_addr, br_addr(br));
      failed = 1'b1;
    end

  a_mispredict: assert property (@(posedge CLK) disable iff (!nRST)
    mispredict == (br.branch_instr && (br.prediction ^ br_taken(br))))
    else begin
      $error("Fail at %0t: mispredict got %b expected %b", $realtime, mispredict,
             br.branch_instr && (br.prediction ^ br_taken(br)));
      failed = 1'b1;
    end

  a_ctl: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST) && $past(pc_en) && !$past(halt) && !$past(ex_flush) |->
      comm_ctl == ctl_value($past(br), $past(jmp), $past(halt_instr), $past(intr_model)))
    else begin
      $error("Fail at %0t: comm_ctl got %h expected %h", $realtime, $sampled(comm_ctl),
             ctl_value($past(br), $past(jmp), $past(halt_instr), $past(intr_model)));
      failed = 1'b1;
    end

  a_jump: assert property (@(posedge CLK) disable iff (!nRST)
    jmp.jump_instr |-> brj_addr == jmp_addr(jmp))
    else begin
      $error("Fail at %0t: brj_addr got %h expected %h", $realtime, brj_addr, jmp_addr(jmp));
      failed = 1'b1;
    end

  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST) && !$past(pc_en) && !$past(halt) |->
      comm_wb == $past(comm_wb) && comm_ctl == $past(comm_ctl))
    else begin
      $error("Commit records changed while the stage was stalled");
      failed = 1'b1;
    end

  a_clear: assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST) && ($past(halt) || ($past(ex_flush) && $past(pc_en))) |->
      comm_wb == '0 && comm_ctl == '0)
    else begin
      $error("Commit records not cleared after halt or flush");
      failed = 1'b1;
    end

  a_reset: assert property (@(posedge CLK)
    !nRST |-> comm_wb == '0 && comm_ctl == '0 && !mul_busy)
    else begin
      $error("Outputs not cleared during reset");
      failed = 1'b1;
    end

endmodule

bind ooo_execute_stage ooo_execute_stage_chk chk (.*);

`default_nettype wire

//--- tb_ooo_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module tb_ooo_execute_stage;

  import exec_pkg::*;

  localparam int NUM_CYCLES = 3000;
  localparam int RST_CYCLES = 16;
  localparam realtime PERIOD = 40ns;

  logic        CLK;
  logic        nRST;
  logic        halt;
  logic        pc_en;
  logic        ex_flush;
  logic        intr;
  logic        intr_taken;
  logic        halt_instr;
  arith_req_t  arith;
  mul_req_t    mul;
  branch_req_t br;
  jump_req_t   jmp;
  logic        mul_busy;
  logic        mispredict;
  word_t       brj_addr;
  commit_wb_t  comm_wb;
  commit_ctl_t comm_ctl;

  logic [15:0] lfsr_state;
  logic        was_busy;

  ooo_execute_stage uut (
    .CLK        (CLK),
    .nRST       (nRST),
    .halt       (halt),
    .pc_en      (pc_en),
    .ex_flush   (ex_flush),
    .intr       (intr),
    .intr_taken (intr_taken),
    .halt_instr (halt_instr),
    .arith      (arith),
    .mul        (mul),
    .br         (br),
    .jmp        (jmp),
    .mul_busy   (mul_busy),
    .mispredict (mispredict),
    .brj_addr   (brj_addr),
    .comm_wb    (comm_wb),
    .comm_ctl   (comm_ctl)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
    end
    return v;
  endfunction

  task automatic drive_random();
    logic done_cycle;
    done_cycle = was_busy && !mul_busy;
    arith.wen            = 1'(rand_bits(1));
    arith.rd             = reg_idx_t'(rand_bits(`EXEC_REG_W));
    arith.aluop          = aluop_t'(4'(rand_bits(4) % 10));
    arith.w_src          = 1'(rand_bits(1));
    arith.port_a         = rand_bits(32);
    arith.port_b         = rand_bits(32);
    arith.reg_file_wdata = rand_bits(32);
    mul.start            = (rand_bits(2) == 0);
    mul.rd               = reg_idx_t'(rand_bits(`EXEC_REG_W));
    mul.is_signed        = 2'(rand_bits(2));
    mul.high_low_sel     = 1'(rand_bits(1));
    mul.rs1_data         = rand_bits(32);
    mul.rs2_data         = rand_bits(32);
    br.branch_instr      = 1'(rand_bits(1));
    br.prediction        = 1'(rand_bits(1));
    br.br_type           = br_type_t'(3'(rand_bits(3) % 6));
    br.pc                = rand_bits(32);
    br.imm_sb            = rand_bits(32);
    br.rs1_data          = rand_bits(32);
    // Equal operands now and then so both outcomes of BEQ and BNE appear
    br.rs2_data          = (rand_bits(2) == 0) ? br.rs1_data : rand_bits(32);
    jmp.jump_instr       = (rand_bits(2) == 0);
    jmp.j_sel            = 1'(rand_bits(1));
    jmp.pc               = rand_bits(32);
    jmp.rs1_data         = rand_bits(32);
    jmp.offset           = rand_bits(32);
    intr                 = (rand_bits(3) == 0);
    intr_taken           = (rand_bits(3) == 0);
    halt_instr           = 1'(rand_bits(1));
    halt                 = (rand_bits(5) == 0);
    ex_flush             = (rand_bits(4) == 0);
    pc_en                = (rand_bits(2) != 0);
    // Stall through the multiply, then capture its done cycle
    if (mul_busy) begin
      pc_en = 1'b0;
    end else if (done_cycle) begin
      pc_en    = 1'b1;
      halt     = 1'b0;
      ex_flush = 1'b0;
    end
    was_busy = mul_busy;
  endtask

  initial begin
    CLK        = 1'b0;
    nRST       = 1'b0;
    halt       = 1'b0;
    pc_en      = 1'b0;
    ex_flush   = 1'b0;
    intr       = 1'b0;
    intr_taken = 1'b0;
    halt_instr = 1'b0;
    arith      = '0;
    mul        = '0;
    br         = '0;
    jmp        = '0;
    lfsr_state = 16'd14230;
    was_busy   = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    #2ns;
    nRST = 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge CLK);
      #2ns;
      drive_random();
    end
    repeat (4) @(posedge CLK);
    if (uut.chk.failed) begin
      $display("Verification failed");
      $fatal(1, "Assertion failures during the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // Stop at the first failing assertion
  initial begin
    wait (uut.chk.failed === 1'b1);
    $display("Verification failed");
    $fatal(1, "An assertion failed");
  end

  initial begin
    #((RST_CYCLES + NUM_CYCLES + 100) * PERIOD);
    $display("Verification failed");
    $fatal(1, "Timeout, the run did not reach its end");
  end

endmodule

`default_nettype wire

//--- ooo_execute_stage.f
+incdir+.
exec_pkg.sv
alu_unit.sv
mul_unit.sv
branch_resolve.sv
stage_reg.sv
ooo_execute_stage.sv
ooo_execute_stage_chk.sv
tb_ooo_execute_stage.sv

//--- Bender.yml
package:
  name: ooo_execute_stage

sources:
  - include_dirs:
      - .
    files:
      - exec_pkg.sv
      - alu_unit.sv
      - mul_unit.sv
      - branch_resolve.sv
      - stage_reg.sv
      - ooo_execute_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - ooo_execute_stage_chk.sv
      - tb_ooo_execute_stage.sv
